// File: logic/busPkg.sv
// shared widths, encodings and instruction formats of the bus datapath, compiled before all RTL
package busPkg;

  ////////////////////////////////////////////////////////////
  // sizes and register indices
  ////////////////////////////////////////////////////////////

  // every bus and register is one byte
  localparam int busWidth = 8;
  // A, B and OUT
  localparam int regCount = 3;

  // bit positions inside a load mask
  localparam int regA = 0;
  localparam int regB = 1;
  localparam int regOut = 2;

  // index width for an n-way select, never below one bit
  function automatic int indexWidth(int count);
    return (count > 1) ? $clog2(count) : 1;
  endfunction

  ////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////

  // instruction class, top nibble of every word
  typedef enum logic [3:0] {
    opNop = 4'h0,
    opMove = 4'h1,
    opLoadImm = 4'h2,
    opAlu = 4'h3
  } opcode_e;

  // what drives the shared bus this cycle
  typedef enum logic [1:0] {
    srcImm = 2'd0,
    srcA = 2'd1,
    srcB = 2'd2,
    srcAlu = 2'd3
  } source_e;

  typedef enum logic [1:0] {
    aluAdd = 2'd0,
    aluSub = 2'd1,
    aluAnd = 2'd2,
    aluXor = 2'd3
  } aluOp_e;

  ////////////////////////////////////////////////////////////
  // instruction word, two views of the same 16 bits
  ////////////////////////////////////////////////////////////

  // register move and ALU form
  typedef struct packed {
    opcode_e opcode;
    logic [regCount-1:0] loadMask;
    source_e source;
    aluOp_e aluOp;
    logic [4:0] pad;
  } moveForm_t;

  // immediate load form, opcode and mask in the same place
  typedef struct packed {
    opcode_e opcode;
    logic [regCount-1:0] loadMask;
    logic pad;
    logic [busWidth-1:0] immediate;
  } immForm_t;

  typedef union packed {
    moveForm_t asMove;
    immForm_t asImm;
  } instrWord_u;

  // decoder output toward bus mux, registers and ALU
  typedef struct packed {
    source_e source;
    logic [regCount-1:0] loadMask;
    aluOp_e aluOp;
    logic [busWidth-1:0] immediate;
  } busCtrl_t;

endpackage

// File: logic/oneHotEncoder.sv
// priority encoder turning register read enables into an input index, used inside register
module oneHotEncoder #(
  parameter int inputCount = 2,
  localparam int selWidth = busPkg::indexWidth(inputCount)
) (
  input logic [inputCount-1:0] select,
  output logic [selWidth-1:0] encodedSelect
);

  // scan upward so the last hit is the highest index
  // nothing set gives index zero
  always_comb begin
    encodedSelect = '0;
    for (int i = 0; i < inputCount; i++) begin
      if (select[i]) begin
        encodedSelect = selWidth'(i);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // index must address a real input
  // matters when inputCount is not a power of two
  always_comb begin
    assert (int'(encodedSelect) < inputCount)
      else $error("encoder index %0d out of range", encodedSelect);
  end

endmodule

// File: logic/register.sv
// byte register with several load sources, highest enabled source wins, one per bus register
module register #(
  parameter int inputCount = 1
) (
  input logic clk,
  input logic nrst,
  input logic [inputCount*busPkg::busWidth-1:0] busInputs,
  input logic [inputCount-1:0] readEnable,
  output logic [busPkg::busWidth-1:0] value
);

  localparam int selWidth = busPkg::indexWidth(inputCount);

  // inputs split into bytes, index 0 in the low byte
  logic [inputCount-1:0][busPkg::busWidth-1:0] inputBytes;
  // which byte to take when loading
  logic [selWidth-1:0] selIndex;
  logic [busPkg::busWidth-1:0] selectedByte;

  ////////////////////////////////////////////////////////////
  // source select
  ////////////////////////////////////////////////////////////

  // highest enable wins
  oneHotEncoder #(
    .inputCount(inputCount)
  ) encoder (
    .select(readEnable),
    .encodedSelect(selIndex)
  );

  // unpack the flat input vector
  assign inputBytes = busInputs;
  assign selectedByte = inputBytes[selIndex];

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  // load on any enable, otherwise hold
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      value <= '0;
    end else if (|readEnable) begin
      value <= selectedByte;
    end
  end

  // no enable at an edge, same value after it
  property holdWithoutEnable;
    @(posedge clk) disable iff (!nrst)
      !(|readEnable) |=> $stable(value);
  endproperty

  holdCheck: assert property (holdWithoutEnable)
    else $error("register changed without a read enable");

endmodule

// File: logic/instructionDecoder.sv
// combinational decoder from a strobed instruction word to bus source, load mask and ALU op
module instructionDecoder (
  input logic instrValid,
  input busPkg::instrWord_u instr,
  output busPkg::busCtrl_t ctrl
);

  // same bit position in both views
  busPkg::opcode_e opcode;

  assign opcode = instr.asMove.opcode;

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    // idle defaults, nothing loads
    ctrl.source = busPkg::srcImm;
    ctrl.loadMask = '0;
    ctrl.aluOp = busPkg::aluAdd;
    // immediate always offered, bus mux picks it only for srcImm
    ctrl.immediate = instr.asImm.immediate;

    if (instrValid) begin
      case (opcode)
        // register to register copy
        // source field decides who drives the bus
        busPkg::opMove: begin
          ctrl.source = instr.asMove.source;
          ctrl.loadMask = instr.asMove.loadMask;
          ctrl.aluOp = instr.asMove.aluOp;
        end

        // immediate view, source forced
        busPkg::opLoadImm: begin
          ctrl.source = busPkg::srcImm;
          ctrl.loadMask = instr.asImm.loadMask;
        end

        // ALU result onto the bus
        // source field of the word ignored
        busPkg::opAlu: begin
          ctrl.source = busPkg::srcAlu;
          ctrl.loadMask = instr.asMove.loadMask;
          ctrl.aluOp = instr.asMove.aluOp;
        end

        // opNop and unknown codes load nothing
        default: begin
          ctrl.loadMask = '0;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // a load without a strobe would corrupt the bank
  always_comb begin
    assert (instrValid || (ctrl.loadMask == '0))
      else $error("load mask %b without instrValid", ctrl.loadMask);
  end

endmodule

// File: logic/alu.sv
// combinational byte ALU on registers A and B, result goes back to the shared bus
module alu (
  input logic [busPkg::busWidth-1:0] a,
  input logic [busPkg::busWidth-1:0] b,
  input busPkg::aluOp_e op,
  output logic [busPkg::busWidth-1:0] result
);

  ////////////////////////////////////////////////////////////
  // operations
  ////////////////////////////////////////////////////////////

  // all results wrap at one byte
  // no carry or borrow kept
  always_comb begin
    case (op)
      // modulo 256 sum
      busPkg::aluAdd: begin
        result = a + b;
      end

      // a minus b, wraps below zero
      busPkg::aluSub: begin
        result = a - b;
      end

      busPkg::aluAnd: begin
        result = a & b;
      end

      busPkg::aluXor: begin
        result = a ^ b;
      end

      // unreachable with a two bit op
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

// File: logic/busDatapath.sv
// top level of the bus datapath, decoder driving a shared byte bus into A, B and OUT
module busDatapath (
  input logic clk,
  input logic nrst,
  input logic instrValid,
  input busPkg::instrWord_u instr,
  input logic extLoad,
  input logic [busPkg::busWidth-1:0] extData,
  output logic [busPkg::busWidth-1:0] outData,
  output logic [busPkg::busWidth-1:0] regAView,
  output logic [busPkg::busWidth-1:0] regBView
);

  busPkg::busCtrl_t ctrl;
  // shared bus byte
  logic [busPkg::busWidth-1:0] busByte;
  logic [busPkg::busWidth-1:0] aluResult;

  ////////////////////////////////////////////////////////////
  // decode and bus mux
  ////////////////////////////////////////////////////////////

  instructionDecoder decoder (
    .instrValid(instrValid),
    .instr(instr),
    .ctrl(ctrl)
  );

  // one driver per cycle, chosen by the decoder
  always_comb begin
    case (ctrl.source)
      busPkg::srcImm: busByte = ctrl.immediate;
      busPkg::srcA: busByte = regAView;
      busPkg::srcB: busByte = regBView;
      default: busByte = aluResult;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // register bank and ALU
  ////////////////////////////////////////////////////////////

  // A, index 1 is the external port and beats the bus
  register #(
    .inputCount(2)
  ) regAInst (
    .clk(clk),
    .nrst(nrst),
    .busInputs({extData, busByte}),
    .readEnable({extLoad, ctrl.loadMask[busPkg::regA]}),
    .value(regAView)
  );

  register #(
    .inputCount(1)
  ) regBInst (
    .clk(clk),
    .nrst(nrst),
    .busInputs(busByte),
    .readEnable(ctrl.loadMask[busPkg::regB]),
    .value(regBView)
  );

  register #(
    .inputCount(1)
  ) regOutInst (
    .clk(clk),
    .nrst(nrst),
    .busInputs(busByte),
    .readEnable(ctrl.loadMask[busPkg::regOut]),
    .value(outData)
  );

  // reads the current A and B, feeds srcAlu
  alu aluInst (
    .a(regAView),
    .b(regBView),
    .op(ctrl.aluOp),
    .result(aluResult)
  );

  // external load always lands in A, even against an instruction load
  extLoadWins: assert property (
    @(posedge clk) disable iff (!nrst)
      extLoad |=> (regAView == $past(extData))
  ) else $error("A did not take extData after extLoad");

endmodule

// File: testbench/busDatapathTb.sv
// directed and random testbench for busDatapath run through sim.f and the Makefile
module busDatapathTb;

  localparam int clkPeriod = 10;
  localparam int resetCycles = 8;
  // directed instruction cycles summed over the test tasks below
  localparam int directedCount = 29;
  localparam int randomCount = 200;
  localparam int timeoutCycles = directedCount + randomCount + resetCycles + 50;

  logic clk;
  logic nrst;
  logic instrValid;
  busPkg::instrWord_u instr;
  logic extLoad;
  logic [busPkg::busWidth-1:0] extData;
  logic [busPkg::busWidth-1:0] outData;
  logic [busPkg::busWidth-1:0] regAView;
  logic [busPkg::busWidth-1:0] regBView;

  // reference copies of A, B and OUT
  logic [busPkg::busWidth-1:0] modelA;
  logic [busPkg::busWidth-1:0] modelB;
  logic [busPkg::busWidth-1:0] modelOut;

  busDatapath dut_i (
    .clk(clk),
    .nrst(nrst),
    .instrValid(instrValid),
    .instr(instr),
    .extLoad(extLoad),
    .extData(extData),
    .outData(outData),
    .regAView(regAView),
    .regBView(regBView)
  );

  always #(clkPeriod / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // instruction builders and reference model
  ////////////////////////////////////////////////////////////

  function automatic busPkg::instrWord_u makeImm(logic [2:0] mask, logic [7:0] imm);
    busPkg::instrWord_u word;
    word = '0;
    word.asImm.opcode = busPkg::opLoadImm;
    word.asImm.loadMask = mask;
    word.asImm.immediate = imm;
    return word;
  endfunction

  function automatic busPkg::instrWord_u makeMove(logic [2:0] mask, busPkg::source_e src);
    busPkg::instrWord_u word;
    word = '0;
    word.asMove.opcode = busPkg::opMove;
    word.asMove.loadMask = mask;
    word.asMove.source = src;
    return word;
  endfunction

  // source field left at srcImm for opAlu to ignore
  function automatic busPkg::instrWord_u makeAlu(logic [2:0] mask, busPkg::aluOp_e op);
    busPkg::instrWord_u word;
    word = '0;
    word.asMove.opcode = busPkg::opAlu;
    word.asMove.loadMask = mask;
    word.asMove.aluOp = op;
    return word;
  endfunction

  // byte arithmetic wrapping at 256
  function automatic logic [7:0] expectAlu(logic [7:0] a, logic [7:0] b, busPkg::aluOp_e op);
    case (op)
      busPkg::aluAdd: return 8'(a + b);
      busPkg::aluSub: return 8'(a - b);
      busPkg::aluAnd: return a & b;
      default: return a ^ b;
    endcase
  endfunction

  // one clock edge of the reference bank
  task automatic stepModel(input logic valid, input busPkg::instrWord_u word,
                           input logic ext, input logic [7:0] extByte);
    logic [2:0] mask;
    logic [7:0] busValue;
    mask = '0;
    busValue = '0;
    if (valid) begin
      case (word.asMove.opcode)
        busPkg::opMove: begin
          mask = word.asMove.loadMask;
          case (word.asMove.source)
            busPkg::srcImm: busValue = word.asImm.immediate;
            busPkg::srcA: busValue = modelA;
            busPkg::srcB: busValue = modelB;
            default: busValue = expectAlu(modelA, modelB, word.asMove.aluOp);
          endcase
        end
        busPkg::opLoadImm: begin
          mask = word.asImm.loadMask;
          busValue = word.asImm.immediate;
        end
        busPkg::opAlu: begin
          mask = word.asMove.loadMask;
          busValue = expectAlu(modelA, modelB, word.asMove.aluOp);
        end
        // nop and unknown codes
        default: mask = '0;
      endcase
    end
    // external port has the higher index on A
    if (ext) begin
      modelA = extByte;
    end else if (mask[busPkg::regA]) begin
      modelA = busValue;
    end
    if (mask[busPkg::regB]) begin
      modelB = busValue;
    end
    if (mask[busPkg::regOut]) begin
      modelOut = busValue;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // compare and drive
  ////////////////////////////////////////////////////////////

  task automatic checkByte(input string name, input logic [busPkg::busWidth-1:0] got,
                           input logic [busPkg::busWidth-1:0] expected);
    if (got !== expected) begin
      $display("[ERROR] t=%0t %s got %02h expected %02h", $time, name, got, expected);
      $display("Done: errors found");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic checkState();
    checkByte("regAView", regAView, modelA);
    checkByte("regBView", regBView, modelB);
    checkByte("outData", outData, modelOut);
  endtask

  // called on a falling edge and returns on the next one
  task automatic runCycle(input logic valid, input busPkg::instrWord_u word,
                          input logic ext, input logic [7:0] extByte);
    instrValid = valid;
    instr = word;
    extLoad = ext;
    extData = extByte;
    stepModel(valid, word, ext, extByte);
    @(negedge clk);
    checkState();
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  // reset values and then loads blocked by a low strobe
  task automatic testResetAndIdle();
    checkState();
    // equal nonzero A and B so a stray ALU write would show
    runCycle(1'b1, makeImm(3'b011, 8'h5C), 1'b0, 8'h00);
    runCycle(1'b0, makeImm(3'b111, 8'hA5), 1'b0, 8'h00);
    runCycle(1'b0, makeMove(3'b110, busPkg::srcAlu), 1'b0, 8'h00);
    runCycle(1'b0, makeAlu(3'b011, busPkg::aluXor), 1'b0, 8'h00);
  endtask

  // all eight masks including zero
  task automatic testImmediateMasks();
    for (int m = 0; m < 8; m++) begin
      runCycle(1'b1, makeImm(3'(m), 8'($urandom)), 1'b0, 8'h00);
    end
  endtask

  task automatic testMoves();
    runCycle(1'b1, makeImm(3'b001, 8'h3C), 1'b0, 8'h00);
    runCycle(1'b1, makeImm(3'b010, 8'h81), 1'b0, 8'h00);
    runCycle(1'b1, makeMove(3'b100, busPkg::srcB), 1'b0, 8'h00);
    runCycle(1'b1, makeMove(3'b100, busPkg::srcA), 1'b0, 8'h00);
    runCycle(1'b1, makeMove(3'b010, busPkg::srcA), 1'b0, 8'h00);
  endtask

  task automatic testAluOps();
    // operands that carry and borrow
    // four distinct results
    runCycle(1'b1, makeImm(3'b001, 8'h9C), 1'b0, 8'h00);
    runCycle(1'b1, makeImm(3'b010, 8'hE7), 1'b0, 8'h00);
    runCycle(1'b1, makeAlu(3'b100, busPkg::aluAdd), 1'b0, 8'h00);
    runCycle(1'b1, makeAlu(3'b100, busPkg::aluSub), 1'b0, 8'h00);
    runCycle(1'b1, makeAlu(3'b100, busPkg::aluAnd), 1'b0, 8'h00);
    runCycle(1'b1, makeAlu(3'b100, busPkg::aluXor), 1'b0, 8'h00);
    // back to back with each using the previous write
    runCycle(1'b1, makeAlu(3'b001, busPkg::aluAdd), 1'b0, 8'h00);
    runCycle(1'b1, makeAlu(3'b010, busPkg::aluSub), 1'b0, 8'h00);
    runCycle(1'b1, makeAlu(3'b101, busPkg::aluAnd), 1'b0, 8'h00);
  endtask

  task automatic testExternalPort();
    runCycle(1'b0, makeImm(3'b000, 8'h00), 1'b1, 8'h5A);
    // A takes extData while B still gets the bus
    runCycle(1'b1, makeImm(3'b011, 8'h11), 1'b1, 8'hE7);
    runCycle(1'b0, makeImm(3'b000, 8'h00), 1'b0, 8'h00);
  endtask

  // mostly valid strobes with opcode 4 as an unknown code
  task automatic testRandomRun();
    busPkg::instrWord_u word;
    logic valid;
    logic ext;
    for (int i = 0; i < randomCount; i++) begin
      word = {4'($urandom_range(0, 4)), 12'($urandom)};
      valid = (($urandom % 5) != 0);
      ext = (($urandom % 8) == 0);
      runCycle(valid, word, ext, 8'($urandom));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h20aa687e));
    clk = 1'b0;
    nrst = 1'b0;
    instrValid = 1'b0;
    instr = '0;
    extLoad = 1'b0;
    extData = '0;
    modelA = '0;
    modelB = '0;
    modelOut = '0;
    repeat (resetCycles) @(negedge clk);
    nrst = 1'b1;

    testResetAndIdle();
    testImmediateMasks();
    testMoves();
    testAluOps();
    testExternalPort();
    testRandomRun();

    instrValid = 1'b0;
    extLoad = 1'b0;
    $display("Done: no errors");
    $finish;
  end

  initial begin
    #(timeoutCycles * clkPeriod);
    $display("timeout: tests did not finish within %0d clock cycles", timeoutCycles);
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: sim.f
logic/busPkg.sv
logic/oneHotEncoder.sv
logic/register.sv
logic/instructionDecoder.sv
logic/alu.sv
logic/busDatapath.sv
testbench/busDatapathTb.sv

// File: Makefile
# Verilator build and run for the bus datapath testbench

VERILATOR ?= verilator
TOP ?= busDatapathTb
DUT_TOP ?= busDatapath
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert
PASS_MSG ?= Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# pass only if the pass message shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
